//--- common/phy_ft_pkg.sv
`default_nettype none

package phy_ft_pkg;

	//////////////////////////////////////////////////////////////////////
	// GMII and link status sizes

	localparam int GMII_DATA_W = 8;

	// Edges a raw status word must hold before it is accepted
	localparam int LINK_DEBOUNCE_CYCLES = 4;

	// Up, speed and duplex packed together
	localparam int STATUS_W = 4;
	localparam int DBNC_CNT_W = $clog2(LINK_DEBOUNCE_CYCLES + 1);

	// In-band status speed encoding
	typedef enum logic [1:0] {
		SPEED_10   = 2'd0,
		SPEED_100  = 2'd1,
		SPEED_1000 = 2'd2,
		SPEED_RSVD = 2'd3
	} speed_t;

	typedef enum logic {
		PORT_0 = 1'b0,
		PORT_1 = 1'b1
	} port_sel_t;

endpackage

`default_nettype wire

//--- common/phy_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface phy_port_if;
	import phy_ft_pkg::*;

	// Debounced link status
	logic link_up;
	speed_t speed;
	logic duplex;

	// Registered GMII receive stream
	logic [GMII_DATA_W-1:0] rxdat;
	logic rxdv;
	logic rxer;

	modport monitor (
		output link_up, speed, duplex,
		output rxdat, rxdv, rxer
	);

	modport failover (
		input link_up, speed, duplex,
		input rxdat, rxdv, rxer
	);

endinterface

`default_nettype wire

//--- dv/phy_ft_tb.sv
`timescale 1ns/1ps
`default_nettype none

module phy_ft_tb;
	import phy_ft_pkg::*;

	logic clk_i;
	logic rst_n_i;
	logic phy0_ibs_up_i, phy0_ibs_dplx_i, phy0_rxdv_i, phy0_rxer_i;
	logic phy1_ibs_up_i, phy1_ibs_dplx_i, phy1_rxdv_i, phy1_rxer_i;
	logic [1:0] phy0_ibs_spd_i, phy1_ibs_spd_i;
	logic [GMII_DATA_W-1:0] phy0_rxdat_i, phy1_rxdat_i, tx_dat_i;
	logic tx_en_i;
	logic [GMII_DATA_W-1:0] phy0_txdat_o, phy1_txdat_o, rx_dat_o;
	logic phy0_txen_o, phy1_txen_o, rx_dv_o, rx_er_o;
	logic link_up_o, duplex_o, active_port_o, link_change_o;
	logic [1:0] speed_o;

	int err_cnt;
	int tmo_cnt;
	logic [31:0] rnd;
	logic chk_rx, chk_tx, hold_up, rsvd_win;
	logic exp_port;
	logic [1:0] exp_speed;
	logic [GMII_DATA_W+1:0] rx_src, rx_exp_d1, rx_exp_q;
	logic [GMII_DATA_W:0] tx_exp_q;

	phy_ft_top uut (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	//////////////////////////////////////////////////////////////////////
	// Random receive and transmit traffic

	initial begin
		{phy0_rxdat_i, phy0_rxdv_i, phy0_rxer_i} = '0;
		{phy1_rxdat_i, phy1_rxdv_i, phy1_rxer_i} = '0;
		{tx_dat_i, tx_en_i} = '0;
		rnd = $urandom(32'h94fb_4b0d);
		forever begin
			@(posedge clk_i);
			#1;
			rnd = $urandom;
			{phy0_rxer_i, phy0_rxdv_i, phy0_rxdat_i} = rnd[9:0];
			{phy1_rxer_i, phy1_rxdv_i, phy1_rxdat_i} = rnd[19:10];
			{tx_en_i, tx_dat_i} = rnd[28:20];
		end
	end

	// Expected streams delayed 2 cycles for receive and 1 for transmit
	assign rx_src = exp_port ? {phy1_rxdv_i, phy1_rxer_i, phy1_rxdat_i} :
		{phy0_rxdv_i, phy0_rxer_i, phy0_rxdat_i};

	always @(posedge clk_i) begin
		rx_exp_d1 <= rx_src;
		rx_exp_q <= rx_exp_d1;
		tx_exp_q <= {tx_en_i, tx_dat_i};
	end

	//////////////////////////////////////////////////////////////////////
	// Checks

	a_reset_vals: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> !link_up_o && !active_port_o && !phy0_txen_o && !phy1_txen_o)
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: link_up_o,active_port_o,phy0_txen_o,phy1_txen_o = %h, expected 0",
			$sampled({link_up_o, active_port_o, phy0_txen_o, phy1_txen_o}));
	end

	a_link_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(link_up_o) |-> speed_o == exp_speed && duplex_o)
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: speed_o,duplex_o = %h, expected %h",
			$sampled({speed_o, duplex_o}), {exp_speed, 1'b1});
	end

	a_link_change: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		link_change_o == ((link_up_o != $past(link_up_o)) ||
			(active_port_o != $past(active_port_o))))
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: link_change_o = %h, expected %h", $sampled(link_change_o),
			!$sampled(link_change_o));
	end

	// Only the port the stimulus expects may ever become active
	a_switch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(active_port_o != $past(active_port_o)) |->
			active_port_o == exp_port && speed_o == exp_speed && duplex_o)
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: active_port_o,speed_o,duplex_o = %h, expected %h",
			$sampled({active_port_o, speed_o, duplex_o}), {exp_port, exp_speed, 1'b1});
	end

	a_hold_up: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(hold_up || rsvd_win) |-> link_up_o == hold_up)
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: link_up_o = %h, expected %h", $sampled(link_up_o), hold_up);
	end

	a_rx_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		chk_rx |-> {rx_dv_o, rx_er_o, rx_dat_o} == rx_exp_q)
	else begin
		err_cnt = err_cnt + 1;
		$display("** Error: rx_dv_o,rx_er_o,rx_dat_o = %h, expected %h",
			$sampled({rx_dv_o, rx_er_o, rx_dat_o}), $sampled(rx_exp_q));
	end

	a_tx_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		chk_tx |-> (exp_port ? {phy1_txen_o, phy1_txdat_o, phy0_txen_o, phy0_txdat_o} :
			{phy0_txen_o, phy0_txdat_o, phy1_txen_o, phy1_txdat_o}) == {tx_exp_q, 9'h0})
	else begin
		err_cnt = err_cnt + 1;
		$display(
			"** Error: phy1_txen_o,phy1_txdat_o,phy0_txen_o,phy0_txdat_o = %h, expected %h",
			$sampled({phy1_txen_o, phy1_txdat_o, phy0_txen_o, phy0_txdat_o}),
			$sampled(exp_port) ? {$sampled(tx_exp_q), 9'h0} : {9'h0, $sampled(tx_exp_q)});
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic advance(input int n);
		repeat (n) @(posedge clk_i);
		#1;
	endtask

	// Duplex follows up so a live port is always full duplex
	task automatic set_status(input logic port, input logic up, input logic [1:0] spd);
		if (port) begin
			{phy1_ibs_up_i, phy1_ibs_spd_i, phy1_ibs_dplx_i} = {up, spd, up};
		end else begin
			{phy0_ibs_up_i, phy0_ibs_spd_i, phy0_ibs_dplx_i} = {up, spd, up};
		end
	endtask

	task automatic wait_state(input logic [1:0] want, input int max_cyc);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < max_cyc && !seen; i++) begin
			advance(1);
			seen = ({link_up_o, active_port_o} == want);
		end
		if (!seen) begin
			tmo_cnt = tmo_cnt + 1;
			$display("Timeout: link_up_o,active_port_o never reached %b within %0d cycles",
				want, max_cyc);
		end
		advance(1);
	endtask

	initial begin
		err_cnt = 0;
		tmo_cnt = 0;
		rst_n_i = 1'b0;
		set_status(1'b0, 1'b0, 2'd0);
		set_status(1'b1, 1'b0, 2'd0);
		{chk_rx, chk_tx, hold_up, rsvd_win} = 4'b0;
		exp_port = 1'b0;
		exp_speed = 2'd2;
		repeat (8) @(posedge clk_i);
		#1 rst_n_i = 1'b1;
		advance(2);
		// Port 0 up at 1000 full duplex
		set_status(1'b0, 1'b1, 2'd2);
		wait_state(2'b10, 5);
		advance(4);
		// Three cycle glitch on port 0
		hold_up = 1'b1;
		set_status(1'b0, 1'b0, 2'd2);
		advance(3);
		set_status(1'b0, 1'b1, 2'd2);
		advance(8);
		chk_rx = 1'b1;
		chk_tx = 1'b1;
		advance(20);
		// Failover to port 1 at 100
		{chk_rx, chk_tx} = 2'b0;
		set_status(1'b1, 1'b1, 2'd1);
		advance(8);
		exp_port = 1'b1;
		exp_speed = 2'd1;
		set_status(1'b0, 1'b0, 2'd2);
		wait_state(2'b11, 8);
		advance(3);
		{chk_rx, chk_tx} = 2'b11;
		advance(20);
		// Port 0 back while port 1 keeps the link
		set_status(1'b0, 1'b1, 2'd2);
		advance(12);
		// Both down and then port 0 at reserved speed
		hold_up = 1'b0;
		set_status(1'b0, 1'b0, 2'd2);
		set_status(1'b1, 1'b0, 2'd1);
		wait_state(2'b01, 8);
		rsvd_win = 1'b1;
		set_status(1'b0, 1'b1, 2'd3);
		advance(12);
		$display("Checks done: %0d errors, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- failover/phy_failover.sv
`timescale 1ns/1ps
`default_nettype none

module phy_failover (
	input  logic clk_i,
	input  logic rst_n_i,
	phy_port_if.failover port0,
	phy_port_if.failover port1,
	input  logic [phy_ft_pkg::GMII_DATA_W-1:0] tx_dat_i,
	input  logic tx_en_i,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] phy0_txdat_o,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] phy1_txdat_o,
	output logic phy0_txen_o,
	output logic phy1_txen_o,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] rx_dat_o,
	output logic rx_dv_o,
	output logic rx_er_o,
	output logic link_up_o,
	output phy_ft_pkg::speed_t speed_o,
	output logic duplex_o,
	output phy_ft_pkg::port_sel_t active_port_o,
	output logic link_change_o
);
	import phy_ft_pkg::*;

	port_sel_t active_q;
	port_sel_t active_nxt;
	logic cur_up;
	logic oth_up;
	logic link_nxt;
	logic changed;
	logic pend_q;
	logic change_q;

	//////////////////////////////////////////////////////////////////////
	// Port selection

	assign cur_up = (active_q == PORT_0) ? port0.link_up : port1.link_up;
	assign oth_up = (active_q == PORT_0) ? port1.link_up : port0.link_up;

	// No preemption, only leave a dead port for a live one
	assign active_nxt = (!cur_up && oth_up) ?
		((active_q == PORT_0) ? PORT_1 : PORT_0) : active_q;

	assign link_nxt = (active_nxt == PORT_0) ? port0.link_up : port1.link_up;
	assign changed = (link_nxt != link_up_o) || (active_nxt != active_q);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			active_q <= PORT_0;
			link_up_o <= 1'b0;
			speed_o <= SPEED_10;
			duplex_o <= 1'b0;
		end else begin
			active_q <= active_nxt;
			link_up_o <= link_nxt;
			speed_o <= (active_nxt == PORT_0) ? port0.speed : port1.speed;
			duplex_o <= (active_nxt == PORT_0) ? port0.duplex : port1.duplex;
		end
	end

	// Back-to-back changes are spread out so each strobe stays one cycle
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			change_q <= 1'b0;
			pend_q <= 1'b0;
		end else begin
			change_q <= (changed || pend_q) && !change_q;
			pend_q <= (changed || pend_q) && change_q;
		end
	end

	assign active_port_o = active_q;
	assign link_change_o = change_q;

	//////////////////////////////////////////////////////////////////////
	// Receive mux and transmit routing

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_dv_o <= 1'b0;
			rx_er_o <= 1'b0;
			phy0_txen_o <= 1'b0;
			phy1_txen_o <= 1'b0;
		end else begin
			rx_dv_o <= (active_q == PORT_0) ? port0.rxdv : port1.rxdv;
			rx_er_o <= (active_q == PORT_0) ? port0.rxer : port1.rxer;
			phy0_txen_o <= tx_en_i && (active_q == PORT_0);
			phy1_txen_o <= tx_en_i && (active_q == PORT_1);
		end
	end

	always_ff @(posedge clk_i) begin
		rx_dat_o <= (active_q == PORT_0) ? port0.rxdat : port1.rxdat;
		phy0_txdat_o <= (active_q == PORT_0) ? tx_dat_i : '0;
		phy1_txdat_o <= (active_q == PORT_1) ? tx_dat_i : '0;
	end

	a_change_single: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		link_change_o |=> !link_change_o
	);

	// New port was reported up by its monitor before the move
	a_switch_to_up: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(active_port_o != $past(active_port_o)) |->
			$past((active_port_o == PORT_0) ? port1.link_up : port0.link_up)
	);

	a_txen_onehot: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(phy0_txen_o && phy1_txen_o)
	);

endmodule

`default_nettype wire

//--- phy_ft_top.f
common/phy_ft_pkg.sv
common/phy_port_if.sv
port_monitor/phy_port_monitor.sv
failover/phy_failover.sv
src/phy_ft_top.sv
dv/phy_ft_tb.sv

//--- port_monitor/phy_port_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module phy_port_monitor (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic ibs_up_i,
	input  phy_ft_pkg::speed_t ibs_spd_i,
	input  logic ibs_dplx_i,
	input  logic [phy_ft_pkg::GMII_DATA_W-1:0] rxdat_i,
	input  logic rxdv_i,
	input  logic rxer_i,
	phy_port_if.monitor port
);
	import phy_ft_pkg::*;

	logic [STATUS_W-1:0] raw_word;
	logic [STATUS_W-1:0] cand_q;
	logic [DBNC_CNT_W-1:0] cnt_q;
	logic accept;

	logic stat_up_q;
	speed_t stat_spd_q;
	logic stat_dplx_q;

	logic [GMII_DATA_W-1:0] rxdat_q;
	logic rxdv_q;
	logic rxer_q;

	//////////////////////////////////////////////////////////////////////
	// In-band status debounce

	assign raw_word = {ibs_up_i, ibs_spd_i, ibs_dplx_i};

	// Last of the equal samples, word goes out on this edge
	assign accept = (raw_word == cand_q) &&
		(cnt_q == DBNC_CNT_W'(LINK_DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cand_q <= {1'b0, SPEED_10, 1'b0};
			cnt_q <= DBNC_CNT_W'(LINK_DEBOUNCE_CYCLES);
		end else if (raw_word != cand_q) begin
			// First sample of a new word
			cand_q <= raw_word;
			cnt_q <= DBNC_CNT_W'(1);
		end else if (cnt_q != DBNC_CNT_W'(LINK_DEBOUNCE_CYCLES)) begin
			cnt_q <= cnt_q + DBNC_CNT_W'(1);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stat_up_q <= 1'b0;
			stat_spd_q <= SPEED_10;
			stat_dplx_q <= 1'b0;
		end else if (accept) begin
			// Reserved speed is never a usable link
			stat_up_q <= ibs_up_i && (ibs_spd_i != SPEED_RSVD);
			stat_spd_q <= ibs_spd_i;
			stat_dplx_q <= ibs_dplx_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Receive stream

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rxdv_q <= 1'b0;
			rxer_q <= 1'b0;
		end else begin
			rxdv_q <= rxdv_i;
			rxer_q <= rxer_i;
		end
	end

	always_ff @(posedge clk_i) begin
		rxdat_q <= rxdat_i;
	end

	assign port.link_up = stat_up_q;
	assign port.speed = stat_spd_q;
	assign port.duplex = stat_dplx_q;
	assign port.rxdat = rxdat_q;
	assign port.rxdv = rxdv_q;
	assign port.rxer = rxer_q;

	// Failover unit must never see an up link at reserved speed
	a_no_rsvd_up: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		port.link_up |-> (port.speed != SPEED_RSVD)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module phy_ft_tb -f phy_ft_top.f -o phy_ft_sim &&
	{ sim_out=$(./obj_dir/phy_ft_sim 2>&1) || true; } &&
	printf '%s\n' "$sim_out" &&
	printf '%s\n' "$sim_out" | grep -qx "Simulation passed" ||
	{ echo "run.sh: no pass line found"; exit 1; }

echo "run.sh: done"

//--- src/phy_ft_top.sv
`timescale 1ns/1ps
`default_nettype none

module phy_ft_top (
	input  logic clk_i,
	input  logic rst_n_i,

	// PHY 0 in-band status and receive
	input  logic phy0_ibs_up_i,
	input  logic [1:0] phy0_ibs_spd_i,
	input  logic phy0_ibs_dplx_i,
	input  logic [phy_ft_pkg::GMII_DATA_W-1:0] phy0_rxdat_i,
	input  logic phy0_rxdv_i,
	input  logic phy0_rxer_i,

	// PHY 1 in-band status and receive
	input  logic phy1_ibs_up_i,
	input  logic [1:0] phy1_ibs_spd_i,
	input  logic phy1_ibs_dplx_i,
	input  logic [phy_ft_pkg::GMII_DATA_W-1:0] phy1_rxdat_i,
	input  logic phy1_rxdv_i,
	input  logic phy1_rxer_i,

	// MAC side
	input  logic [phy_ft_pkg::GMII_DATA_W-1:0] tx_dat_i,
	input  logic tx_en_i,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] phy0_txdat_o,
	output logic phy0_txen_o,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] phy1_txdat_o,
	output logic phy1_txen_o,
	output logic [phy_ft_pkg::GMII_DATA_W-1:0] rx_dat_o,
	output logic rx_dv_o,
	output logic rx_er_o,
	output logic link_up_o,
	output logic [1:0] speed_o,
	output logic duplex_o,
	output logic active_port_o,
	output logic link_change_o
);
	import phy_ft_pkg::*;

	speed_t fo_speed;
	port_sel_t fo_active;

	phy_port_if port0_if ();
	phy_port_if port1_if ();

	//////////////////////////////////////////////////////////////////////
	// Port monitors

	phy_port_monitor u_port0_mon (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.ibs_up_i   (phy0_ibs_up_i),
		.ibs_spd_i  (speed_t'(phy0_ibs_spd_i)),
		.ibs_dplx_i (phy0_ibs_dplx_i),
		.rxdat_i    (phy0_rxdat_i),
		.rxdv_i     (phy0_rxdv_i),
		.rxer_i     (phy0_rxer_i),
		.port       (port0_if)
	);

	phy_port_monitor u_port1_mon (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.ibs_up_i   (phy1_ibs_up_i),
		.ibs_spd_i  (speed_t'(phy1_ibs_spd_i)),
		.ibs_dplx_i (phy1_ibs_dplx_i),
		.rxdat_i    (phy1_rxdat_i),
		.rxdv_i     (phy1_rxdv_i),
		.rxer_i     (phy1_rxer_i),
		.port       (port1_if)
	);

	//////////////////////////////////////////////////////////////////////
	// Failover

	phy_failover u_failover (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.port0         (port0_if),
		.port1         (port1_if),
		.tx_dat_i      (tx_dat_i),
		.tx_en_i       (tx_en_i),
		.phy0_txdat_o  (phy0_txdat_o),
		.phy1_txdat_o  (phy1_txdat_o),
		.phy0_txen_o   (phy0_txen_o),
		.phy1_txen_o   (phy1_txen_o),
		.rx_dat_o      (rx_dat_o),
		.rx_dv_o       (rx_dv_o),
		.rx_er_o       (rx_er_o),
		.link_up_o     (link_up_o),
		.speed_o       (fo_speed),
		.duplex_o      (duplex_o),
		.active_port_o (fo_active),
		.link_change_o (link_change_o)
	);

	assign speed_o = 2'(fo_speed);
	assign active_port_o = 1'(fo_active);

endmodule

`default_nettype wire
